//--- Bender.yml
package:
  name: arcade_io

sources:
  - files:
      - hw/arcade_pkg.sv
      - hw/cfg_if.sv
      - hw/cfg_regs.sv
      - hw/rom_loader.sv
      - hw/reset_ctrl.sv
      - hw/control_mux.sv
      - hw/audio_mix.sv
      - hw/arcade_io_top.sv
  - target: test
    files:
      - tests/tb_clkgen.sv
      - tests/arcade_io_properties.sv
      - tests/tb_arcade_io.sv

//--- hw/arcade_io_top.sv
// Top level of the board glue, connects register block, loader, reset, inputs and audio
`timescale 1ns/10ps

module arcade_io_top #(
	parameter int RESET_HOLD = 65535
) (
	input  logic                  clk_sys,
	input  logic                  rst_n_i,

	// ==============================
	// AXI4-Lite configuration
	// ==============================
	input  logic [3:0]            s_axi_awaddr_i,
	input  logic                  s_axi_awvalid_i,
	output logic                  s_axi_awready_o,
	input  logic [31:0]           s_axi_wdata_i,
	input  logic [3:0]            s_axi_wstrb_i,
	input  logic                  s_axi_wvalid_i,
	output logic                  s_axi_wready_o,
	output logic [1:0]            s_axi_bresp_o,
	output logic                  s_axi_bvalid_o,
	input  logic                  s_axi_bready_i,
	input  logic [3:0]            s_axi_araddr_i,
	input  logic                  s_axi_arvalid_i,
	output logic                  s_axi_arready_o,
	output logic [31:0]           s_axi_rdata_o,
	output logic [1:0]            s_axi_rresp_o,
	output logic                  s_axi_rvalid_o,
	input  logic                  s_axi_rready_i,

	// ROM download and memory commands
	input  logic                  dl_active_i,
	input  logic                  dl_wr_i,
	input  logic [7:0]            dl_index_i,
	input  arcade_pkg::dl_addr_t  dl_addr_i,
	input  logic [7:0]            dl_data_i,
	output logic                  mem_wr_o,
	output arcade_pkg::mem_sel_e  mem_sel_o,
	output arcade_pkg::mem_addr_t mem_addr_o,
	output logic [1:0]            mem_be_o,
	output logic [15:0]           mem_data_o,

	output logic                  core_reset_o,

	// Controls
	input  logic [7:0]            joy1_i,
	input  logic [7:0]            joy2_i,
	output logic [7:0]            in_0_o,
	output logic [7:0]            in_1_o,
	output logic [7:0]            in_2_o,
	output logic [7:0]            in_3_o,

	// Audio
	input  arcade_pkg::sample_t   core_audio_l_i,
	input  arcade_pkg::sample_t   core_audio_r_i,
	input  arcade_pkg::sample_t   ext_audio_l_i,
	input  arcade_pkg::sample_t   ext_audio_r_i,
	output logic                  audio_l_o,
	output logic                  audio_r_o
);

	cfg_if cfg ();

	cfg_regs u_cfg_regs (
		.clk_sys         (clk_sys),
		.rst_n_i         (rst_n_i),
		.s_axi_awaddr_i  (s_axi_awaddr_i),
		.s_axi_awvalid_i (s_axi_awvalid_i),
		.s_axi_awready_o (s_axi_awready_o),
		.s_axi_wdata_i   (s_axi_wdata_i),
		.s_axi_wstrb_i   (s_axi_wstrb_i),
		.s_axi_wvalid_i  (s_axi_wvalid_i),
		.s_axi_wready_o  (s_axi_wready_o),
		.s_axi_bresp_o   (s_axi_bresp_o),
		.s_axi_bvalid_o  (s_axi_bvalid_o),
		.s_axi_bready_i  (s_axi_bready_i),
		.s_axi_araddr_i  (s_axi_araddr_i),
		.s_axi_arvalid_i (s_axi_arvalid_i),
		.s_axi_arready_o (s_axi_arready_o),
		.s_axi_rdata_o   (s_axi_rdata_o),
		.s_axi_rresp_o   (s_axi_rresp_o),
		.s_axi_rvalid_o  (s_axi_rvalid_o),
		.s_axi_rready_i  (s_axi_rready_i),
		.cfg             (cfg.regs)
	);

	rom_loader u_rom_loader (
		.clk_sys     (clk_sys),
		.rst_n_i     (rst_n_i),
		.dl_active_i (dl_active_i),
		.dl_wr_i     (dl_wr_i),
		.dl_index_i  (dl_index_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.mem_wr_o    (mem_wr_o),
		.mem_sel_o   (mem_sel_o),
		.mem_addr_o  (mem_addr_o),
		.mem_be_o    (mem_be_o),
		.mem_data_o  (mem_data_o),
		.cfg         (cfg.loader)
	);

	reset_ctrl #(
		.RESET_HOLD (RESET_HOLD)
	) u_reset_ctrl (
		.clk_sys      (clk_sys),
		.rst_n_i      (rst_n_i),
		.cfg          (cfg.user),
		.rom_loaded_i (cfg.rom_loaded),
		.core_reset_o (core_reset_o)
	);

	control_mux u_control_mux (
		.clk_sys (clk_sys),
		.rst_n_i (rst_n_i),
		.cfg     (cfg.user),
		.joy1_i  (joy1_i),
		.joy2_i  (joy2_i),
		.in_0_o  (in_0_o),
		.in_1_o  (in_1_o),
		.in_2_o  (in_2_o),
		.in_3_o  (in_3_o)
	);

	audio_mix u_audio_mix (
		.clk_sys        (clk_sys),
		.rst_n_i        (rst_n_i),
		.cfg            (cfg.user),
		.core_audio_l_i (core_audio_l_i),
		.core_audio_r_i (core_audio_r_i),
		.ext_audio_l_i  (ext_audio_l_i),
		.ext_audio_r_i  (ext_audio_r_i),
		.audio_l_o      (audio_l_o),
		.audio_r_o      (audio_r_o)
	);

endmodule

//--- hw/arcade_pkg.sv
// Shared widths, types, ROM region constants and register offsets used by all the RTL
package arcade_pkg;

	// ==============================
	// Download and memory addressing
	// ==============================

	localparam int DL_ADDR_W  = 25;
	localparam int MEM_ADDR_W = 23;

	typedef logic [DL_ADDR_W-1:0]  dl_addr_t;
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

	// Sprite ROMs follow main, sound and tile ROMs in the download image
	localparam dl_addr_t SPRITE_BASE = 25'h12000;

	// Target port of a memory write command
	typedef enum logic {
		MEM_PROGRAM = 1'b0,
		MEM_SPRITE  = 1'b1
	} mem_sel_e;

	// ==============================
	// Audio
	// ==============================

	localparam int SAMPLE_W = 16;
	localparam int MIX_W    = 17;

	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic [MIX_W-1:0]    mix_t;

	// Recentres doubled core audio around zero
	localparam mix_t MIX_OFFSET = 17'h04000;

	// ==============================
	// Register map
	// ==============================

	localparam logic [3:0] REG_CTRL   = 4'h0;
	localparam logic [3:0] REG_STATUS = 4'h4;

	// CTRL bit positions
	localparam int CTRL_ROTATE     = 0;
	localparam int CTRL_SERVICE    = 1;
	localparam int CTRL_SOFT_RESET = 2;
	localparam int CTRL_EXT_AUDIO  = 3;

endpackage

//--- hw/audio_mix.sv
// Mixes core sound with the external sample track and drives two 1-bit sigma-delta DACs
`timescale 1ns/10ps

module audio_mix (
	input  logic                clk_sys,
	input  logic                rst_n_i,
	cfg_if.user                 cfg,
	input  arcade_pkg::sample_t core_audio_l_i,
	input  arcade_pkg::sample_t core_audio_r_i,
	input  arcade_pkg::sample_t ext_audio_l_i,
	input  arcade_pkg::sample_t ext_audio_r_i,
	output logic                audio_l_o,
	output logic                audio_r_o
);

	arcade_pkg::sample_t core_s [2];
	arcade_pkg::sample_t ext_s  [2];
	logic                dac_bit [2];

	// Index 0 is left, 1 is right
	assign core_s[0] = core_audio_l_i;
	assign core_s[1] = core_audio_r_i;
	assign ext_s[0]  = ext_audio_l_i;
	assign ext_s[1]  = ext_audio_r_i;

	for (genvar ch = 0; ch < 2; ch++) begin : g_chan
		arcade_pkg::mix_t ext_x;
		arcade_pkg::mix_t sum_q;
		arcade_pkg::mix_t dac_in_q;
		arcade_pkg::mix_t acc_q;
		logic [arcade_pkg::MIX_W:0] acc_next;

		// Signed external track, muted when disabled
		assign ext_x = cfg.ext_audio_en ?
			{ext_s[ch][arcade_pkg::SAMPLE_W-1], ext_s[ch]} : '0;

		// Carry out of the accumulator is the DAC bit
		assign acc_next = {1'b0, acc_q} + {1'b0, dac_in_q};

		always_ff @(posedge clk_sys) begin
			if (!rst_n_i) begin
				sum_q       <= '0;
				dac_in_q    <= '0;
				acc_q       <= '0;
				dac_bit[ch] <= 1'b0;
			end else begin
				sum_q    <= ext_x + {core_s[ch], 1'b0} - arcade_pkg::MIX_OFFSET;
				// Signed sum to offset binary
				dac_in_q <= {~sum_q[arcade_pkg::MIX_W-1], sum_q[arcade_pkg::MIX_W-2:0]};

				acc_q       <= acc_next[arcade_pkg::MIX_W-1:0];
				dac_bit[ch] <= acc_next[arcade_pkg::MIX_W];
			end
		end
	end

	assign audio_l_o = dac_bit[0];
	assign audio_r_o = dac_bit[1];

endmodule

//--- hw/cfg_if.sv
// Operator options and ROM status shared by the register block and the game glue logic
`timescale 1ns/10ps

interface cfg_if;

	// Options from the CTRL register
	logic rotate;
	logic service;
	logic soft_reset;
	logic ext_audio_en;

	// Set once a full ROM image has been downloaded
	logic rom_loaded;

	modport regs (
		output rotate, service, soft_reset, ext_audio_en,
		input  rom_loaded
	);

	modport loader (
		output rom_loaded
	);

	modport user (
		input rotate, service, soft_reset, ext_audio_en
	);

endinterface

//--- hw/cfg_regs.sv
// AXI4-Lite slave holding the CTRL option bits and reporting ROM status, sits beside the glue
`timescale 1ns/10ps

module cfg_regs (
	input  logic        clk_sys,
	input  logic        rst_n_i,

	// Write address and data
	input  logic [3:0]  s_axi_awaddr_i,
	input  logic        s_axi_awvalid_i,
	output logic        s_axi_awready_o,
	input  logic [31:0] s_axi_wdata_i,
	input  logic [3:0]  s_axi_wstrb_i,
	input  logic        s_axi_wvalid_i,
	output logic        s_axi_wready_o,

	// Write response
	output logic [1:0]  s_axi_bresp_o,
	output logic        s_axi_bvalid_o,
	input  logic        s_axi_bready_i,

	// Read address and data
	input  logic [3:0]  s_axi_araddr_i,
	input  logic        s_axi_arvalid_i,
	output logic        s_axi_arready_o,
	output logic [31:0] s_axi_rdata_o,
	output logic [1:0]  s_axi_rresp_o,
	output logic        s_axi_rvalid_o,
	input  logic        s_axi_rready_i,

	cfg_if.regs         cfg
);

	logic [3:0]  ctrl_q;
	logic        wr_accept;
	logic        wr_fire;
	logic        rd_accept;
	logic        rd_fire;
	logic [31:0] rd_value;

	// ==============================
	// Write channel
	// ==============================

	// Both address and data must be present, and no response may be outstanding
	assign wr_accept = s_axi_awvalid_i & s_axi_wvalid_i & ~s_axi_awready_o & ~s_axi_bvalid_o;
	assign wr_fire   = s_axi_awready_o & s_axi_awvalid_i & s_axi_wvalid_i;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			s_axi_awready_o <= 1'b0;
			s_axi_wready_o  <= 1'b0;
			s_axi_bvalid_o  <= 1'b0;
			ctrl_q          <= '0;
		end else begin
			s_axi_awready_o <= wr_accept;
			s_axi_wready_o  <= wr_accept;

			if (wr_fire) begin
				s_axi_bvalid_o <= 1'b1;
				// Only the low byte holds defined bits
				if (s_axi_awaddr_i == arcade_pkg::REG_CTRL && s_axi_wstrb_i[0]) begin
					ctrl_q <= s_axi_wdata_i[3:0];
				end
			end else if (s_axi_bvalid_o && s_axi_bready_i) begin
				s_axi_bvalid_o <= 1'b0;
			end
		end
	end

	// Always OKAY
	assign s_axi_bresp_o = 2'b00;

	// ==============================
	// Read channel
	// ==============================

	assign rd_accept = s_axi_arvalid_i & ~s_axi_arready_o & ~s_axi_rvalid_o;
	assign rd_fire   = s_axi_arready_o & s_axi_arvalid_i;

	// Unmapped offsets read as zero
	always_comb begin
		rd_value = '0;
		case (s_axi_araddr_i)
			arcade_pkg::REG_CTRL:   rd_value[3:0] = ctrl_q;
			arcade_pkg::REG_STATUS: rd_value[0]   = cfg.rom_loaded;
			default:                rd_value      = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			s_axi_arready_o <= 1'b0;
			s_axi_rvalid_o  <= 1'b0;
		end else begin
			s_axi_arready_o <= rd_accept;
			if (rd_fire) begin
				s_axi_rvalid_o <= 1'b1;
			end else if (s_axi_rvalid_o && s_axi_rready_i) begin
				s_axi_rvalid_o <= 1'b0;
			end
		end
	end

	// Read data captured with the address handshake
	always_ff @(posedge clk_sys) begin
		if (rd_fire) begin
			s_axi_rdata_o <= rd_value;
		end
	end

	assign s_axi_rresp_o = 2'b00;

	// Options straight from CTRL
	assign cfg.rotate       = ctrl_q[arcade_pkg::CTRL_ROTATE];
	assign cfg.service      = ctrl_q[arcade_pkg::CTRL_SERVICE];
	assign cfg.soft_reset   = ctrl_q[arcade_pkg::CTRL_SOFT_RESET];
	assign cfg.ext_audio_en = ctrl_q[arcade_pkg::CTRL_EXT_AUDIO];

endmodule

//--- hw/control_mux.sv
// Encodes joystick and button bits into the core's active-low input bytes
`timescale 1ns/10ps

module control_mux (
	input  logic       clk_sys,
	input  logic       rst_n_i,
	cfg_if.user        cfg,
	input  logic [7:0] joy1_i,
	input  logic [7:0] joy2_i,
	output logic [7:0] in_0_o,
	output logic [7:0] in_1_o,
	output logic [7:0] in_2_o,
	output logic [7:0] in_3_o
);

	logic p1_right;
	logic p1_left;
	logic p1_down;
	logic p1_up;

	// Rotated cabinet, directions turn clockwise
	always_comb begin
		if (cfg.rotate) begin
			p1_up    = joy1_i[0];
			p1_left  = joy1_i[3];
			p1_down  = joy1_i[1];
			p1_right = joy1_i[2];
		end else begin
			p1_right = joy1_i[0];
			p1_left  = joy1_i[1];
			p1_down  = joy1_i[2];
			p1_up    = joy1_i[3];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			in_0_o <= 8'hFF;
			in_1_o <= 8'hFF;
			in_2_o <= 8'hFF;
			in_3_o <= 8'hFF;
		end else begin
			// service, unused, tilt, fire, start2, start1, coin2, coin1
			in_0_o <= ~{cfg.service, 1'b0, 1'b0, joy1_i[4], joy1_i[7], joy1_i[6],
				1'b0, joy1_i[5]};
			in_1_o <= ~{4'b0000, p1_down, p1_up, p1_right, p1_left};
			in_2_o <= ~{3'b000, joy2_i[4], joy2_i[2], joy2_i[3], joy2_i[0], joy2_i[1]};
			// DIP switches
			in_3_o <= ~8'h02;
		end
	end

endmodule

//--- hw/reset_ctrl.sv
// Core reset generator, holds reset until ROM load and adds a delayed second pulse
`timescale 1ns/10ps

module reset_ctrl #(
	parameter int RESET_HOLD = 65535
) (
	input  logic  clk_sys,
	input  logic  rst_n_i,
	cfg_if.user   cfg,
	input  logic  rom_loaded_i,
	output logic  core_reset_o
);

	localparam int CNT_W = $clog2(RESET_HOLD + 1);

	logic             hold;
	logic [CNT_W-1:0] count_q;

	// Reset causes other than the board reset
	assign hold = cfg.soft_reset | ~rom_loaded_i;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i || hold) begin
			count_q      <= CNT_W'(RESET_HOLD);
			core_reset_o <= 1'b1;
		end else begin
			if (count_q != '0) begin
				count_q <= count_q - 1'b1;
			end
			// Second pulse, the core needs it some time after release
			core_reset_o <= (count_q == CNT_W'(1));
		end
	end

endmodule

//--- hw/rom_loader.sv
// Maps the byte download stream onto program or sprite memory write commands, flags ROM loaded
`timescale 1ns/10ps

module rom_loader (
	input  logic                 clk_sys,
	input  logic                 rst_n_i,

	input  logic                 dl_active_i,
	input  logic                 dl_wr_i,
	input  logic [7:0]           dl_index_i,
	input  arcade_pkg::dl_addr_t dl_addr_i,
	input  logic [7:0]           dl_data_i,

	output logic                 mem_wr_o,
	output arcade_pkg::mem_sel_e mem_sel_o,
	output arcade_pkg::mem_addr_t mem_addr_o,
	output logic [1:0]           mem_be_o,
	output logic [15:0]          mem_data_o,

	cfg_if.loader                cfg
);

	logic                 dl_wr_q;
	logic                 dl_active_q;
	logic                 wr_edge;
	logic                 is_sprite;
	arcade_pkg::dl_addr_t sp_off;

	// New byte for the ROM image
	assign wr_edge = dl_wr_i & ~dl_wr_q & dl_active_i & (dl_index_i == 8'd0);

	assign is_sprite = (dl_addr_i >= arcade_pkg::SPRITE_BASE);
	assign sp_off    = dl_addr_i - arcade_pkg::SPRITE_BASE;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			dl_wr_q         <= 1'b0;
			dl_active_q     <= 1'b0;
			mem_wr_o        <= 1'b0;
			cfg.rom_loaded  <= 1'b0;
		end else begin
			dl_wr_q     <= dl_wr_i;
			dl_active_q <= dl_active_i;
			mem_wr_o    <= wr_edge;
			// End of download, sticky until reset
			if (dl_active_q && !dl_active_i) begin
				cfg.rom_loaded <= 1'b1;
			end
		end
	end

	// Command payload
	always_ff @(posedge clk_sys) begin
		if (wr_edge) begin
			mem_data_o <= {dl_data_i, dl_data_i};
			if (is_sprite) begin
				// Pairs of sprite ROMs interleave into 32-bit words
				mem_sel_o  <= arcade_pkg::MEM_SPRITE;
				mem_addr_o <= {sp_off[23:16], sp_off[13:0], sp_off[15]};
				mem_be_o   <= {sp_off[14], ~sp_off[14]};
			end else begin
				mem_sel_o  <= arcade_pkg::MEM_PROGRAM;
				mem_addr_o <= dl_addr_i[23:1];
				mem_be_o   <= {dl_addr_i[0], ~dl_addr_i[0]};
			end
		end
	end

endmodule

//--- tb.f
hw/arcade_pkg.sv
hw/cfg_if.sv
hw/cfg_regs.sv
hw/rom_loader.sv
hw/reset_ctrl.sv
hw/control_mux.sv
hw/audio_mix.sv
hw/arcade_io_top.sv
tests/tb_clkgen.sv
tests/arcade_io_properties.sv
tests/tb_arcade_io.sv

//--- tests/arcade_io_properties.sv
// Concurrent checks on the board glue outputs that are bound into arcade_io_top
`timescale 1ns/10ps

module arcade_io_properties (
	input logic clk_sys,
	input logic rst_n_i,
	input logic mem_wr_i,
	input logic core_reset_i,
	input logic rom_loaded_i,
	input logic bvalid_i,
	input logic bready_i
);

	// Read by the testbench
	int fail_count = 0;

	// Write command is a single-cycle strobe
	single_strobe: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		mem_wr_i |=> !mem_wr_i)
	else begin
		$error("mem_wr_o high on two consecutive cycles");
		fail_count++;
	end

	// No ROM means the core stays in reset
	reset_without_rom: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		!rom_loaded_i |-> core_reset_i)
	else begin
		$error("core_reset_o low while no ROM is loaded");
		fail_count++;
	end

	bvalid_held: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		bvalid_i && !bready_i |=> bvalid_i)
	else begin
		$error("s_axi_bvalid_o dropped before s_axi_bready_i");
		fail_count++;
	end

endmodule

bind arcade_io_top arcade_io_properties u_arcade_io_properties (
	.clk_sys      (clk_sys),
	.rst_n_i      (rst_n_i),
	.mem_wr_i     (mem_wr_o),
	.core_reset_i (core_reset_o),
	.rom_loaded_i (cfg.rom_loaded),
	.bvalid_i     (s_axi_bvalid_o),
	.bready_i     (s_axi_bready_i)
);

//--- tests/tb_arcade_io.sv
// Directed testbench for the arcade board glue with tb_arcade_io as the simulation top
`timescale 1ns/10ps

module tb_arcade_io;

	localparam int RESET_HOLD = 16;
	// About 12600 cycles in all and mostly the three audio windows of 4096
	localparam int CYCLE_LIMIT = 20000;

	logic                  clk_sys;
	logic                  rst_n_i;
	logic [3:0]            s_axi_awaddr_i;
	logic                  s_axi_awvalid_i;
	logic                  s_axi_awready_o;
	logic [31:0]           s_axi_wdata_i;
	logic [3:0]            s_axi_wstrb_i;
	logic                  s_axi_wvalid_i;
	logic                  s_axi_wready_o;
	logic [1:0]            s_axi_bresp_o;
	logic                  s_axi_bvalid_o;
	logic                  s_axi_bready_i;
	logic [3:0]            s_axi_araddr_i;
	logic                  s_axi_arvalid_i;
	logic                  s_axi_arready_o;
	logic [31:0]           s_axi_rdata_o;
	logic [1:0]            s_axi_rresp_o;
	logic                  s_axi_rvalid_o;
	logic                  s_axi_rready_i;
	logic                  dl_active_i;
	logic                  dl_wr_i;
	logic [7:0]            dl_index_i;
	arcade_pkg::dl_addr_t  dl_addr_i;
	logic [7:0]            dl_data_i;
	logic                  mem_wr_o;
	arcade_pkg::mem_sel_e  mem_sel_o;
	arcade_pkg::mem_addr_t mem_addr_o;
	logic [1:0]            mem_be_o;
	logic [15:0]           mem_data_o;
	logic                  core_reset_o;
	logic [7:0]            joy1_i;
	logic [7:0]            joy2_i;
	logic [7:0]            in_0_o;
	logic [7:0]            in_1_o;
	logic [7:0]            in_2_o;
	logic [7:0]            in_3_o;
	arcade_pkg::sample_t   core_audio_l_i;
	arcade_pkg::sample_t   core_audio_r_i;
	arcade_pkg::sample_t   ext_audio_l_i;
	arcade_pkg::sample_t   ext_audio_r_i;
	logic                  audio_l_o;
	logic                  audio_r_o;

	integer seed;
	int     cycle_count;

	tb_clkgen u_clkgen (
		.clk_o   (clk_sys),
		.rst_n_o (rst_n_i)
	);

	arcade_io_top #(
		.RESET_HOLD (RESET_HOLD)
	) UUT (.*);

	// ==============================
	// Helpers
	// ==============================

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic expect_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else report_failure($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// Inputs change and outputs are sampled 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			report_failure("Timeout, the tests did not finish within the cycle limit");
		end
	end

	// A bound property failure ends the run at once
	always @(UUT.u_arcade_io_properties.fail_count) begin
		if (UUT.u_arcade_io_properties.fail_count != 0) begin
			report_failure("A bound property check failed, see the error above");
		end
	end

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
		s_axi_awaddr_i  = addr;
		s_axi_wdata_i   = data;
		s_axi_wstrb_i   = 4'h1;
		s_axi_awvalid_i = 1'b1;
		s_axi_wvalid_i  = 1'b1;
		next_cycle();
		while (!s_axi_awready_o) next_cycle();
		expect_value("s_axi_wready_o", s_axi_wready_o, 1'b1);
		// Handshake completes on the next edge
		next_cycle();
		s_axi_awvalid_i = 1'b0;
		s_axi_wvalid_i  = 1'b0;
		expect_value("s_axi_bvalid_o", s_axi_bvalid_o, 1'b1);
		expect_value("s_axi_bresp_o", s_axi_bresp_o, 2'b00);
		// Response must wait for bready
		next_cycle();
		expect_value("s_axi_bvalid_o", s_axi_bvalid_o, 1'b1);
		s_axi_bready_i = 1'b1;
		next_cycle();
		s_axi_bready_i = 1'b0;
		expect_value("s_axi_bvalid_o", s_axi_bvalid_o, 1'b0);
	endtask

	task automatic read_and_compare(input logic [3:0] addr, input logic [31:0] exp);
		s_axi_araddr_i  = addr;
		s_axi_arvalid_i = 1'b1;
		next_cycle();
		while (!s_axi_arready_o) next_cycle();
		next_cycle();
		s_axi_arvalid_i = 1'b0;
		expect_value("s_axi_rvalid_o", s_axi_rvalid_o, 1'b1);
		expect_value("s_axi_rresp_o", s_axi_rresp_o, 2'b00);
		expect_value($sformatf("s_axi_rdata_o at 0x%0h", addr), s_axi_rdata_o, exp);
		s_axi_rready_i = 1'b1;
		next_cycle();
		s_axi_rready_i = 1'b0;
		expect_value("s_axi_rvalid_o", s_axi_rvalid_o, 1'b0);
	endtask

	// ==============================
	// Tests
	// ==============================

	task automatic reset_values();
		expect_value("mem_wr_o", mem_wr_o, 1'b0);
		expect_value("audio_l_o", audio_l_o, 1'b0);
		expect_value("audio_r_o", audio_r_o, 1'b0);
		expect_value("s_axi_awready_o", s_axi_awready_o, 1'b0);
		expect_value("s_axi_wready_o", s_axi_wready_o, 1'b0);
		expect_value("s_axi_bvalid_o", s_axi_bvalid_o, 1'b0);
		expect_value("s_axi_arready_o", s_axi_arready_o, 1'b0);
		expect_value("s_axi_rvalid_o", s_axi_rvalid_o, 1'b0);
		expect_value("core_reset_o", core_reset_o, 1'b1);
		expect_value("in_0_o", in_0_o, 8'hFF);
		expect_value("in_1_o", in_1_o, 8'hFF);
		expect_value("in_2_o", in_2_o, 8'hFF);
		expect_value("in_3_o", in_3_o, 8'hFF);
	endtask

	task automatic register_access();
		read_and_compare(arcade_pkg::REG_CTRL, 32'h0);
		read_and_compare(arcade_pkg::REG_STATUS, 32'h0);
		// Only the four option bits exist
		axi_write(arcade_pkg::REG_CTRL, 32'hFFFF_FFF6);
		read_and_compare(arcade_pkg::REG_CTRL, 32'h6);
		axi_write(arcade_pkg::REG_CTRL, 32'h9);
		read_and_compare(arcade_pkg::REG_CTRL, 32'h9);
		read_and_compare(4'h8, 32'h0);
		read_and_compare(4'hC, 32'h0);
		axi_write(4'hC, 32'hF);
		read_and_compare(arcade_pkg::REG_CTRL, 32'h9);
		axi_write(arcade_pkg::REG_CTRL, 32'h0);
		read_and_compare(arcade_pkg::REG_CTRL, 32'h0);
	endtask

	task automatic download_byte(input arcade_pkg::dl_addr_t addr, input logic [7:0] index);
		logic [7:0]            data;
		arcade_pkg::dl_addr_t  off;
		arcade_pkg::mem_addr_t exp_addr;
		logic [1:0]            exp_be;
		arcade_pkg::mem_sel_e  exp_sel;
		data = 8'($random(seed));
		if (addr < arcade_pkg::SPRITE_BASE) begin
			exp_sel  = arcade_pkg::MEM_PROGRAM;
			exp_addr = arcade_pkg::mem_addr_t'(addr >> 1);
			exp_be   = addr[0] ? 2'b10 : 2'b01;
		end else begin
			// Offset bits 23..16, 13..0 and 15 form the word address
			off      = addr - arcade_pkg::SPRITE_BASE;
			exp_sel  = arcade_pkg::MEM_SPRITE;
			exp_addr = (23'(off[23:16]) << 15) | (23'(off[13:0]) << 1) | 23'(off[15]);
			exp_be   = off[14] ? 2'b10 : 2'b01;
		end
		dl_index_i = index;
		dl_addr_i  = addr;
		dl_data_i  = data;
		dl_wr_i    = 1'b1;
		next_cycle();
		if (index == 8'd0) begin
			expect_value("mem_wr_o", mem_wr_o, 1'b1);
			expect_value("mem_sel_o", mem_sel_o, exp_sel);
			expect_value("mem_addr_o", mem_addr_o, exp_addr);
			expect_value("mem_be_o", mem_be_o, exp_be);
			expect_value("mem_data_o", mem_data_o, {data, data});
		end else begin
			expect_value("mem_wr_o", mem_wr_o, 1'b0);
		end
		dl_wr_i = 1'b0;
		next_cycle();
		expect_value("mem_wr_o", mem_wr_o, 1'b0);
		next_cycle();
	endtask

	task automatic download_mapping();
		dl_active_i = 1'b1;
		next_cycle();
		download_byte(25'h00000, 8'd0);
		download_byte(25'h0A001, 8'd0);
		download_byte(arcade_pkg::SPRITE_BASE, 8'd0);
		download_byte(arcade_pkg::SPRITE_BASE + 25'h4000, 8'd0);
		download_byte(arcade_pkg::SPRITE_BASE + 25'h8000, 8'd0);
		download_byte(arcade_pkg::SPRITE_BASE + 25'h14003, 8'd0);
		// Other download indexes are not ROM data
		download_byte(25'h00010, 8'd1);
	endtask

	// Waits for release and then for one single-cycle pulse in the hold window
	task automatic release_pulse();
		int n;
		n = 0;
		while (core_reset_o) next_cycle();
		while (!core_reset_o && n <= RESET_HOLD + 2) begin
			next_cycle();
			n++;
		end
		assert (core_reset_o && n >= RESET_HOLD - 2 && n <= RESET_HOLD + 2)
		else report_failure($sformatf("Second reset pulse not seen in its window (%0d cycles)", n));
		for (int i = 0; i < 4; i++) begin
			next_cycle();
			expect_value("core_reset_o", core_reset_o, 1'b0);
		end
	endtask

	task automatic reset_sequence();
		expect_value("core_reset_o", core_reset_o, 1'b1);
		dl_active_i = 1'b0;
		next_cycle();
		// ROM loaded flag sets on this edge
		expect_value("core_reset_o", core_reset_o, 1'b1);
		next_cycle();
		expect_value("core_reset_o", core_reset_o, 1'b0);
		release_pulse();
		read_and_compare(arcade_pkg::REG_STATUS, 32'h1);

		axi_write(arcade_pkg::REG_CTRL, 32'h1 << arcade_pkg::CTRL_SOFT_RESET);
		for (int i = 0; i < RESET_HOLD + 4; i++) begin
			expect_value("core_reset_o", core_reset_o, 1'b1);
			next_cycle();
		end
		fork
			axi_write(arcade_pkg::REG_CTRL, 32'h0);
			release_pulse();
		join
	endtask

	// Expected input bytes packed as {in_0, in_1, in_2, in_3}
	function automatic logic [31:0] encode_inputs(input logic [7:0] j1, input logic [7:0] j2,
		input logic rot, input logic svc);
		logic       r;
		logic       l;
		logic       d;
		logic       u;
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		{u, d, l, r} = j1[3:0];
		if (rot) begin
			// Clockwise turn where right reads as up
			{u, d, l, r} = {j1[0], j1[1], j1[3], j1[2]};
		end
		b0 = {svc, 2'b00, j1[4], j1[7], j1[6], 1'b0, j1[5]};
		b1 = {4'h0, d, u, r, l};
		b2 = {3'h0, j2[4], j2[2], j2[3], j2[0], j2[1]};
		return {~b0, ~b1, ~b2, 8'hFD};
	endfunction

	task automatic input_encoding();
		logic [31:0] exp;
		logic [1:0]  mode;
		for (int m = 0; m < 4; m++) begin
			mode = 2'(m);
			axi_write(arcade_pkg::REG_CTRL, (32'(mode[0]) << arcade_pkg::CTRL_ROTATE) |
				(32'(mode[1]) << arcade_pkg::CTRL_SERVICE));
			for (int k = 0; k < 11; k++) begin
				joy1_i = (k < 8) ? (8'h01 << k) : 8'($random(seed));
				joy2_i = 8'($random(seed));
				next_cycle();
				exp = encode_inputs(joy1_i, joy2_i, mode[0], mode[1]);
				expect_value("in_0_o", in_0_o, exp[31:24]);
				expect_value("in_1_o", in_1_o, exp[23:16]);
				expect_value("in_2_o", in_2_o, exp[15:8]);
				expect_value("in_3_o", in_3_o, exp[7:0]);
			end
		end
		axi_write(arcade_pkg::REG_CTRL, 32'h0);
	endtask

	// Unsigned DAC level is the signed mix shifted up by half scale
	function automatic int predicted_level(input logic [15:0] core, input logic [15:0] ext,
		input logic en);
		int          s;
		logic [16:0] level;
		s = 2 * int'(core) - 32'h4000;
		if (en) begin
			s = s + int'($signed(ext));
		end
		level = 17'(s + 32'h10000);
		return int'(level);
	endfunction

	task automatic check_density(input string name, input int ones, input int level);
		// Over 4096 samples the expected count is level / 32
		assert (ones * 32 >= level - 64 && ones * 32 <= level + 64)
		else report_failure($sformatf("FAILED %s ones: got 0x%0h, expected 0x%0h +/- 2",
			name, ones, (level + 16) / 32));
	endtask

	task automatic measure_audio(input logic [15:0] core_l, input logic [15:0] core_r,
		input logic [15:0] ext_l, input logic [15:0] ext_r, input logic en);
		int ones_l;
		int ones_r;
		axi_write(arcade_pkg::REG_CTRL, 32'(en) << arcade_pkg::CTRL_EXT_AUDIO);
		core_audio_l_i = core_l;
		core_audio_r_i = core_r;
		ext_audio_l_i  = ext_l;
		ext_audio_r_i  = ext_r;
		// Two register stages before the accumulator
		repeat (4) next_cycle();
		ones_l = 0;
		ones_r = 0;
		for (int i = 0; i < 4096; i++) begin
			next_cycle();
			ones_l += audio_l_o;
			ones_r += audio_r_o;
		end
		check_density("audio_l_o", ones_l, predicted_level(core_l, ext_l, en));
		check_density("audio_r_o", ones_r, predicted_level(core_r, ext_r, en));
	endtask

	task automatic audio_density();
		measure_audio(16'h4000, 16'h6000, 16'h1000, 16'hF000, 1'b1);
		measure_audio(16'h4000, 16'h6000, 16'h1000, 16'hF000, 1'b0);
		// Extremes where the right channel wraps
		measure_audio(16'h0000, 16'hFFFF, 16'h8000, 16'h7FFF, 1'b1);
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		seed            = 32'h2f39_2fd4;
		cycle_count     = 0;
		s_axi_awaddr_i  = '0;
		s_axi_awvalid_i = 1'b0;
		s_axi_wdata_i   = '0;
		s_axi_wstrb_i   = '0;
		s_axi_wvalid_i  = 1'b0;
		s_axi_bready_i  = 1'b0;
		s_axi_araddr_i  = '0;
		s_axi_arvalid_i = 1'b0;
		s_axi_rready_i  = 1'b0;
		dl_active_i     = 1'b0;
		dl_wr_i         = 1'b0;
		dl_index_i      = '0;
		dl_addr_i       = '0;
		dl_data_i       = '0;
		joy1_i          = '0;
		joy2_i          = '0;
		core_audio_l_i  = '0;
		core_audio_r_i  = '0;
		ext_audio_l_i   = '0;
		ext_audio_r_i   = '0;

		wait (rst_n_i === 1'b1);
		reset_values();
		register_access();
		download_mapping();
		reset_sequence();
		input_encoding();
		audio_density();
		next_cycle();

		if (UUT.u_arcade_io_properties.fail_count == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("FAIL: see errors above");
			$fatal(1, "Bound property checks reported errors");
		end
	end

endmodule

//--- tests/tb_clkgen.sv
// Clock and board reset source for the testbench, 20 ns period with reset held for 5 cycles
`timescale 1ns/10ps

module tb_clkgen (
	output logic clk_o,
	output logic rst_n_o
);

	localparam int RESET_CYCLES = 5;

	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// Release 1 ns after an edge, like all other stimulus
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1;
		rst_n_o = 1'b1;
	end

endmodule
